/* hw/icache_cfg_pkg.sv */
package icache_cfg_pkg;

    localparam int ADDR_W   = 32;                     // Fetch address width
    localparam int DATA_W   = 32;                     // One instruction per line
    localparam int SET_BITS = 6;
    localparam int NUM_SETS = 1 << SET_BITS;          // 64 sets
    localparam int TAG_BITS = ADDR_W - SET_BITS - 2;  // 24 bits above set and byte offset

    // Address split as seen by the tag compare
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set_idx;
        logic [1:0]          offset;     // Byte offset, always zero for word fetches
    } addr_fields_t;

    // Same word, raw for the memory bus, split for the lookup
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } icache_addr_u;

    typedef struct packed {
        logic         valid;
        icache_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;    // One-cycle pulse
        logic              hit;
        logic [DATA_W-1:0] instr;
    } fetch_rsp_t;

endpackage

/* hw/icache_bus_pkg.sv */
package icache_bus_pkg;

    // Register side, 12-bit offsets
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Memory side, full byte address
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apb_mem_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    localparam logic [11:0] CSR_CTRL   = 12'h000;  // Enable and flush
    localparam logic [11:0] CSR_HITS   = 12'h004;
    localparam logic [11:0] CSR_MISSES = 12'h008;

    localparam int CTRL_EN_BIT    = 0;
    localparam int CTRL_FLUSH_BIT = 1;  // Write 1 to start, reads as 0

endpackage

/* hw/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [icache_cfg_pkg::SET_BITS-1:0]  index,
    input  logic [icache_cfg_pkg::TAG_BITS-1:0]  tag,
    input  logic                                 fill,
    input  logic [$clog2(NUM_WAYS)-1:0]          fill_way,
    input  logic [icache_cfg_pkg::DATA_W-1:0]    fill_instr,
    input  logic                                 inval,
    input  logic [icache_cfg_pkg::SET_BITS-1:0]  inval_index,
    output logic                                 hit,
    output logic [$clog2(NUM_WAYS)-1:0]          hit_way,
    output logic [icache_cfg_pkg::DATA_W-1:0]    hit_instr
);

    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int NUM_SETS = icache_cfg_pkg::NUM_SETS;

    logic [icache_cfg_pkg::TAG_BITS-1:0] tag_mem   [NUM_SETS][NUM_WAYS];
    logic [icache_cfg_pkg::DATA_W-1:0]   instr_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]                 valid_q   [NUM_SETS];  // One bit per way

    // Line payload, written only on refill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[index][fill_way]   <= tag;
            instr_mem[index][fill_way] <= fill_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else begin
            if (inval) begin
                valid_q[inval_index] <= '0;        // Whole set at once
            end
            if (fill) begin
                valid_q[index][fill_way] <= 1'b1;
            end
        end
    end

    // All ways compared in parallel
    // At most one way can match since a tag is filled only on a miss
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        hit_instr = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[index][w] && (tag_mem[index][w] == tag)) begin
                hit       = 1'b1;
                hit_way   = WAY_W'(w);
                hit_instr = instr_mem[index][w];
            end
        end
    end

endmodule

/* hw/icache_lru.sv */
`timescale 1ns/1ps

module icache_lru #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 access,
    input  logic [icache_cfg_pkg::SET_BITS-1:0]  set_idx,
    input  logic [$clog2(NUM_WAYS)-1:0]          used_way,
    input  logic                                 clear,
    output logic [$clog2(NUM_WAYS)-1:0]          victim_way
);

    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int NUM_SETS = icache_cfg_pkg::NUM_SETS;
    localparam logic [WAY_W-1:0] AGE_MAX = WAY_W'(NUM_WAYS - 1);  // Saturation point

    logic [WAY_W-1:0] age_q [NUM_SETS][NUM_WAYS];
    logic [WAY_W-1:0] used_age;

    assign used_age = age_q[set_idx][used_way];

    // Ways no older than the used one move up a step, so ages stay a true ranking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (clear) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                age_q[set_idx][w] <= '0;
            end
        end else if (access) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_W'(w) == used_way) begin
                    age_q[set_idx][w] <= '0;          // Most recently used
                end else if (age_q[set_idx][w] <= used_age && age_q[set_idx][w] != AGE_MAX) begin
                    age_q[set_idx][w] <= age_q[set_idx][w] + 1'b1;
                end
            end
        end
    end

    // Oldest way, lowest index wins a tie
    always_comb begin
        logic [WAY_W-1:0] max_age;
        max_age    = age_q[set_idx][0];
        victim_way = '0;
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (age_q[set_idx][w] > max_age) begin  // Strict compare keeps the lower way
                max_age    = age_q[set_idx][w];
                victim_way = WAY_W'(w);
            end
        end
    end

endmodule

/* hw/icache_refill.sv */
`timescale 1ns/1ps

module icache_refill #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  icache_cfg_pkg::fetch_req_t           fetch_req,
    output logic                                 req_ready,
    output icache_cfg_pkg::fetch_rsp_t           fetch_rsp,
    output icache_bus_pkg::apb_mem_req_t         mem_req,
    input  icache_bus_pkg::apb_rsp_t             mem_rsp,
    input  logic                                 enable,
    input  logic                                 flush,
    output logic [icache_cfg_pkg::SET_BITS-1:0]  lk_index,     // To lookup
    output logic [icache_cfg_pkg::TAG_BITS-1:0]  lk_tag,
    output logic                                 fill,
    output logic [$clog2(NUM_WAYS)-1:0]          fill_way,
    output logic [icache_cfg_pkg::DATA_W-1:0]    fill_instr,
    output logic                                 inval,
    output logic [icache_cfg_pkg::SET_BITS-1:0]  inval_index,
    output logic                                 lru_access,   // To age counters
    output logic [icache_cfg_pkg::SET_BITS-1:0]  lru_set,
    output logic [$clog2(NUM_WAYS)-1:0]          lru_way,
    output logic                                 lru_clear,
    input  logic                                 hit,
    input  logic [$clog2(NUM_WAYS)-1:0]          hit_way,
    input  logic [icache_cfg_pkg::DATA_W-1:0]    hit_instr,
    input  logic [$clog2(NUM_WAYS)-1:0]          victim_way,
    output logic                                 hit_evt,
    output logic                                 miss_evt
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,   // Arrays read with the registered address
        SETUP,    // APB setup phase
        ACCESS,   // APB access phase, held through wait states
        FLUSH     // One set invalidated per cycle
    } state_t;

    state_t                               state;
    icache_cfg_pkg::icache_addr_u         addr_q;
    logic [icache_cfg_pkg::SET_BITS-1:0]  flush_idx;
    logic                                 flush_pend;  // Flush waits for the fetch in flight
    logic                                 do_fill;     // Enable as seen at lookup
    logic                                 rsp_valid;
    logic                                 rsp_hit;
    logic [icache_cfg_pkg::DATA_W-1:0]    rsp_instr;
    logic                                 accept;
    logic                                 mem_done;

    assign req_ready = (state == IDLE) && !flush_pend;
    assign accept    = fetch_req.valid && req_ready;
    assign mem_done  = (state == ACCESS) && mem_rsp.pready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FLUSH;    // Valid bits cleared by a full flush after reset
            flush_idx  <= '0;
            flush_pend <= 1'b0;
            do_fill    <= 1'b0;
            rsp_valid  <= 1'b0;
            rsp_hit    <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (flush) begin
                flush_pend <= 1'b1;
            end else if (state == IDLE) begin
                flush_pend <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (flush_pend) begin
                        state <= FLUSH;
                    end else if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    do_fill <= enable;
                    if (enable && hit) begin
                        rsp_valid <= 1'b1;
                        rsp_hit   <= 1'b1;
                        state     <= IDLE;
                    end else begin
                        state <= SETUP;          // Disabled cache always goes to memory
                    end
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (mem_rsp.pready) begin
                        rsp_valid <= 1'b1;
                        rsp_hit   <= 1'b0;
                        state     <= IDLE;
                    end
                end
                FLUSH: begin
                    flush_idx <= flush_idx + 1'b1;   // Wraps back to zero at the end
                    if (flush_idx == '1) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and returned word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= fetch_req.addr;
        end
        if (state == LOOKUP) begin
            rsp_instr <= hit_instr;
        end else if (mem_done) begin
            rsp_instr <= mem_rsp.prdata;           // PSLVERR ignored
        end
    end

    assign fetch_rsp.valid = rsp_valid;
    assign fetch_rsp.hit   = rsp_hit;
    assign fetch_rsp.instr = rsp_instr;

    assign mem_req.psel    = (state == SETUP) || (state == ACCESS);
    assign mem_req.penable = (state == ACCESS);
    assign mem_req.pwrite  = 1'b0;                 // Read only
    assign mem_req.paddr   = addr_q.raw;
    assign mem_req.pwdata  = '0;

    assign lk_index    = addr_q.f.set_idx;
    assign lk_tag      = addr_q.f.tag;
    assign fill        = mem_done && do_fill;      // Same edge as the response
    assign fill_way    = victim_way;
    assign fill_instr  = mem_rsp.prdata;
    assign inval       = (state == FLUSH);
    assign inval_index = flush_idx;

    assign hit_evt  = (state == LOOKUP) && enable && hit;
    assign miss_evt = (state == LOOKUP) && enable && !hit;

    // Age update on a counted hit or on the fill
    assign lru_access = hit_evt || fill;
    assign lru_way    = fill ? victim_way : hit_way;
    assign lru_clear  = (state == FLUSH);
    assign lru_set    = (state == FLUSH) ? flush_idx : addr_q.f.set_idx;

endmodule

/* hw/icache_csr.sv */
`timescale 1ns/1ps

module icache_csr (
    input  logic                      clk,
    input  logic                      rst_n,
    input  icache_bus_pkg::apb_req_t  csr_req,
    output icache_bus_pkg::apb_rsp_t  csr_rsp,
    input  logic                      hit_evt,
    input  logic                      miss_evt,
    output logic                      enable,
    output logic                      flush
);

    logic        wr_en;
    logic        wr_ctrl;
    logic        wr_hits;
    logic        wr_misses;
    logic [31:0] hits_q;
    logic [31:0] misses_q;
    logic [31:0] rdata;

    assign wr_en     = csr_req.psel && csr_req.penable && csr_req.pwrite;  // Access phase
    assign wr_ctrl   = wr_en && (csr_req.paddr == icache_bus_pkg::CSR_CTRL);
    assign wr_hits   = wr_en && (csr_req.paddr == icache_bus_pkg::CSR_HITS);
    assign wr_misses = wr_en && (csr_req.paddr == icache_bus_pkg::CSR_MISSES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable   <= 1'b0;
            flush    <= 1'b0;
            hits_q   <= '0;
            misses_q <= '0;
        end else begin
            flush <= wr_ctrl && csr_req.pwdata[icache_bus_pkg::CTRL_FLUSH_BIT];  // Single pulse
            if (wr_ctrl) begin
                enable <= csr_req.pwdata[icache_bus_pkg::CTRL_EN_BIT];
            end
            // Any write clears, wraps on overflow
            if (wr_hits) begin
                hits_q <= '0;
            end else if (hit_evt) begin
                hits_q <= hits_q + 1'b1;
            end
            if (wr_misses) begin
                misses_q <= '0;
            end else if (miss_evt) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (csr_req.paddr)
            icache_bus_pkg::CSR_CTRL:   rdata = {31'd0, enable};
            icache_bus_pkg::CSR_HITS:   rdata = hits_q;
            icache_bus_pkg::CSR_MISSES: rdata = misses_q;
            default:                    rdata = '0;   // Unmapped reads as zero
        endcase
    end

    assign csr_rsp.pready  = 1'b1;                    // No wait states
    assign csr_rsp.pslverr = 1'b0;
    assign csr_rsp.prdata  = (csr_req.psel && !csr_req.pwrite) ? rdata : '0;

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int NUM_WAYS = 4   // 2, 4 or 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  icache_cfg_pkg::fetch_req_t    fetch_req,
    output logic                          req_ready,
    output icache_cfg_pkg::fetch_rsp_t    fetch_rsp,
    output icache_bus_pkg::apb_mem_req_t  mem_req,
    input  icache_bus_pkg::apb_rsp_t      mem_rsp,
    input  icache_bus_pkg::apb_req_t      csr_req,
    output icache_bus_pkg::apb_rsp_t      csr_rsp
);

    localparam int WAY_W = $clog2(NUM_WAYS);

    // Refill to lookup
    logic [icache_cfg_pkg::SET_BITS-1:0]  lk_index;
    logic [icache_cfg_pkg::TAG_BITS-1:0]  lk_tag;
    logic                                 fill;
    logic [WAY_W-1:0]                     fill_way;
    logic [icache_cfg_pkg::DATA_W-1:0]    fill_instr;
    logic                                 inval;
    logic [icache_cfg_pkg::SET_BITS-1:0]  inval_index;
    logic                                 hit;
    logic [WAY_W-1:0]                     hit_way;
    logic [icache_cfg_pkg::DATA_W-1:0]    hit_instr;

    // Refill to age counters
    logic                                 lru_access;
    logic [icache_cfg_pkg::SET_BITS-1:0]  lru_set;
    logic [WAY_W-1:0]                     lru_way;
    logic                                 lru_clear;
    logic [WAY_W-1:0]                     victim_way;

    // Refill and register block
    logic                                 enable;
    logic                                 flush;
    logic                                 hit_evt;
    logic                                 miss_evt;

    icache_lookup #(
        .NUM_WAYS (NUM_WAYS)
    ) i_lookup (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (lk_index),
        .tag         (lk_tag),
        .fill        (fill),
        .fill_way    (fill_way),
        .fill_instr  (fill_instr),
        .inval       (inval),
        .inval_index (inval_index),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_instr   (hit_instr)
    );

    icache_lru #(
        .NUM_WAYS (NUM_WAYS)
    ) i_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .access     (lru_access),
        .set_idx    (lru_set),
        .used_way   (lru_way),
        .clear      (lru_clear),
        .victim_way (victim_way)
    );

    icache_refill #(
        .NUM_WAYS (NUM_WAYS)
    ) i_refill (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .req_ready   (req_ready),
        .fetch_rsp   (fetch_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .enable      (enable),
        .flush       (flush),
        .lk_index    (lk_index),
        .lk_tag      (lk_tag),
        .fill        (fill),
        .fill_way    (fill_way),
        .fill_instr  (fill_instr),
        .inval       (inval),
        .inval_index (inval_index),
        .lru_access  (lru_access),
        .lru_set     (lru_set),
        .lru_way     (lru_way),
        .lru_clear   (lru_clear),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_instr   (hit_instr),
        .victim_way  (victim_way),
        .hit_evt     (hit_evt),
        .miss_evt    (miss_evt)
    );

    icache_csr i_csr (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr_req  (csr_req),
        .csr_rsp  (csr_rsp),
        .hit_evt  (hit_evt),
        .miss_evt (miss_evt),
        .enable   (enable),
        .flush    (flush)
    );

endmodule

/* tests/icache_asserts.sv */
`timescale 1ns/1ps

module icache_asserts (
    input logic                          clk,
    input logic                          rst_n,
    input icache_cfg_pkg::fetch_req_t    fetch_req,
    input logic                          req_ready,
    input icache_cfg_pkg::fetch_rsp_t    fetch_rsp,
    input icache_bus_pkg::apb_mem_req_t  mem_req
);

    logic in_flight;   // Accepted fetch still waiting for its response

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (fetch_req.valid && req_ready) begin
            in_flight <= 1'b1;
        end else if (fetch_rsp.valid) begin
            in_flight <= 1'b0;
        end
    end

    // Access phase opens only after a setup cycle
    penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req.penable) |-> $past(mem_req.psel && !mem_req.penable))
        else $error("memory penable rose without a setup cycle");

    rsp_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_rsp.valid |-> in_flight)
        else $error("fetch response without an accepted request");

    ready_low_on_refill: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.psel |-> !req_ready)
        else $error("req_ready high during a memory read");

endmodule

bind icache_top icache_asserts i_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch_req (fetch_req),
    .req_ready (req_ready),
    .fetch_rsp (fetch_rsp),
    .mem_req   (mem_req)
);

/* tests/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam int          NUM_WAYS    = 4;
    localparam int          CLK_PERIOD  = 100;
    localparam int          RST_CYCLES  = 3;
    localparam int          LINE_CYCLES = 200;           // Watchdog budget per golden line
    localparam logic [31:0] INSTR_KEY   = 32'h5A5A5A5A;  // Memory word is address XOR key

    logic                         clk;
    logic                         rst_n;
    icache_cfg_pkg::fetch_req_t   fetch_req;
    logic                         req_ready;
    icache_cfg_pkg::fetch_rsp_t   fetch_rsp;
    icache_bus_pkg::apb_mem_req_t mem_req;
    icache_bus_pkg::apb_rsp_t     mem_rsp;
    icache_bus_pkg::apb_req_t     csr_req;
    icache_bus_pkg::apb_rsp_t     csr_rsp;

    // Golden commands, one entry per data line
    logic [7:0]  cmd_kind [$];
    logic [31:0] cmd_arg  [$];
    logic [31:0] cmd_val  [$];
    int          num_lines;
    logic        loaded;
    logic        passed;
    logic        fail_shown;
    int          mem_delay;    // Wait states for the current read
    int          mem_wait;

    icache_top #(
        .NUM_WAYS (NUM_WAYS)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .req_ready (req_ready),
        .fetch_rsp (fetch_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .csr_req   (csr_req),
        .csr_rsp   (csr_rsp)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            fail_shown = 1'b1;
            $display("test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // All driving and sampling happens 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tests/icache_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/icache_golden.txt for reading");
            fail_shown = 1'b1;
            $display("test failed");
            $fatal(1, "no stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%c %h %h", kind, a, b);
            if (n == 3 && kind != "#") begin    // Comment and blank lines skipped
                cmd_kind.push_back(kind);
                cmd_arg.push_back(a);
                cmd_val.push_back(b);
            end
        end
        $fclose(fd);
        num_lines = cmd_kind.size();
    endtask

    task automatic run_fetch(input logic [31:0] addr, input logic exp_hit);
        while (!req_ready) begin
            next_cycle();                        // Busy or flushing
        end
        fetch_req.valid    = 1'b1;
        fetch_req.addr.raw = addr;
        next_cycle();                            // Accepted on this edge
        fetch_req.valid = 1'b0;
        while (!fetch_rsp.valid) begin
            next_cycle();
        end
        check_value("fetch_rsp.hit", 32'(fetch_rsp.hit), 32'(exp_hit));
        check_value("fetch_rsp.instr", fetch_rsp.instr, addr ^ INSTR_KEY);
    endtask

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        csr_req.psel    = 1'b1;
        csr_req.penable = 1'b0;
        csr_req.pwrite  = 1'b1;
        csr_req.paddr   = addr;
        csr_req.pwdata  = data;
        next_cycle();
        csr_req.penable = 1'b1;                  // Access phase
        next_cycle();
        check_value("csr_rsp.pready", 32'(csr_rsp.pready), 32'd1);
        csr_req = '0;
        next_cycle();                            // Flush request reaches the fetch FSM
    endtask

    task automatic csr_read(input logic [11:0] addr, input logic [31:0] exp);
        csr_req.psel    = 1'b1;
        csr_req.penable = 1'b0;
        csr_req.pwrite  = 1'b0;
        csr_req.paddr   = addr;
        csr_req.pwdata  = '0;
        next_cycle();
        csr_req.penable = 1'b1;
        next_cycle();
        check_value("csr_rsp.pready", 32'(csr_rsp.pready), 32'd1);
        check_value("csr_rsp.pslverr", 32'(csr_rsp.pslverr), 32'd0);
        check_value("csr_rsp.prdata", csr_rsp.prdata, exp);
        csr_req = '0;
    endtask

    // APB memory, 0 to 3 wait states per read
    initial begin
        void'($urandom(32'h5769));
        mem_rsp   = '0;
        mem_delay = 0;
        mem_wait  = 0;
        forever begin
            next_cycle();
            mem_rsp.pready = 1'b0;
            if (mem_req.psel && !mem_req.penable) begin
                mem_delay = $urandom_range(3, 0);
                mem_wait  = 0;
            end else if (mem_req.psel && mem_req.penable) begin
                if (mem_wait == mem_delay) begin
                    mem_rsp.pready = 1'b1;
                    mem_rsp.prdata = mem_req.paddr ^ INSTR_KEY;
                end else begin
                    mem_wait++;
                end
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        fetch_req  = '0;
        csr_req    = '0;
        loaded     = 1'b0;
        passed     = 1'b0;
        fail_shown = 1'b0;
        num_lines  = 0;
        load_golden();
        loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < num_lines; i++) begin
            case (cmd_kind[i])
                "F": run_fetch(cmd_arg[i], cmd_val[i][0]);
                "W": csr_write(cmd_arg[i][11:0], cmd_val[i]);
                "R": csr_read(cmd_arg[i][11:0], cmd_val[i]);
                default: begin
                    $display("unknown command kind in golden line %0d", i);
                    fail_shown = 1'b1;
                    $display("test failed");
                    $fatal(1, "bad golden file");
                end
            endcase
        end
        passed = 1'b1;
        $display("test passed");
        $finish;
    end

    // Reset flush plus a fixed budget per command
    initial begin
        wait (loaded);
        repeat (num_lines * LINE_CYCLES + icache_cfg_pkg::NUM_SETS + RST_CYCLES) @(posedge clk);
        $display("watchdog expired, a fetch or register access never completed");
        fail_shown = 1'b1;
        $display("test failed");
        $fatal(1, "timeout");
    end

    // Run stopped early, e.g. by an assertion
    final begin
        if (!passed && !fail_shown) begin
            $display("simulation ended before all golden commands completed");
            $display("test failed");
        end
    end

endmodule

/* tests/icache_golden.txt */
# kind arg value, hex. F: fetch byte address, expected hit flag
# W: CSR write offset, data. R: CSR read offset, expected data
W 000 00000001
F 00001000 0
F 00002004 0
F 00001000 1
F 00002004 1
R 004 00000002
R 008 00000002
W 004 00000000
W 008 00000000
R 004 00000000
R 008 00000000
# Five tags in set 0x10, four ways
F 00010040 0
F 00020040 0
F 00030040 0
F 00040040 0
F 00050040 0
F 00010040 0
F 00050040 1
F 00020040 0
F 00040040 1
F 00030040 0
R 004 00000002
R 008 00000008
# Cache disabled, nothing filled or counted
W 000 00000000
F 00003008 0
F 00003008 0
F 00050040 0
R 008 00000008
W 000 00000001
F 00003008 0
F 00003008 1
F 00050040 1
# Flush with enable kept
W 000 00000003
F 00001000 0
F 00001000 1
F 00003008 0
R 004 00000005
R 008 0000000B
R 000 00000001
R 00C 00000000
W 008 00000000
R 008 00000000

/* files.f */
hw/icache_cfg_pkg.sv
hw/icache_bus_pkg.sv
hw/icache_lookup.sv
hw/icache_lru.sv
hw/icache_refill.sv
hw/icache_csr.sv
hw/icache_top.sv
tests/icache_asserts.sv
tests/tb_icache.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_icache -f files.f -o Vtb_icache

./obj_dir/Vtb_icache 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
